//--- include/sfm_params.svh
`ifndef SFM_PARAMS_SVH
`define SFM_PARAMS_SVH

// unsigned Q0.16 addend
`define SFM_ADD_WIDTH   16

// unsigned Q16.16 datapath word
`define SFM_ACC_WIDTH   32
`define SFM_FRAC_BITS   16

// multiply-add latency and number of circulating partial sums
`define SFM_FMA_STAGES  3

`define SFM_FIFO_DEPTH  12

// newton-raphson refinement steps
`define SFM_INV_ITERS   2

// linear seed x0 = 48/17 - 32/17 * d in Q16.16
`define SFM_SEED_A      32'h0002_D2D2
`define SFM_SEED_B      32'h0001_E1E2

// signed normalization shift
`define SFM_SHIFT_WIDTH 6

`endif

//--- rtl/sfm_pkg.sv
`include "sfm_params.svh"

package sfm_pkg;

    typedef logic [`SFM_ADD_WIDTH-1:0] add_word_t;
    typedef logic [`SFM_ACC_WIDTH-1:0] acc_word_t;
    typedef logic signed [`SFM_SHIFT_WIDTH-1:0] shift_t;
    typedef logic [1:0] in_flight_t;

    // ADD: a + c, MUL: a * b, NMADD: c - a * b
    typedef enum logic [1:0] {
        OP_ADD,
        OP_MUL,
        OP_NMADD
    } fma_op_e;

    typedef enum logic [3:0] {
        IDLE,
        COMPUTING,
        FINISHING,
        REDUCTION,
        INVERSION,
        INV_FMA,
        INV_MUL,
        FINISHED
    } acc_state_e;

endpackage

//--- rtl/sfm_fma_if.sv
`timescale 1ns/1ns

interface sfm_fma_if import sfm_pkg::*; ();

    // request side, one per cycle, no backpressure
    logic      req_valid;
    fma_op_e   req_op;
    acc_word_t op_a;
    acc_word_t op_b;
    acc_word_t op_c;

    // result side, fixed latency after the request
    logic      res_valid;
    acc_word_t res;

    modport ctrl (
        output req_valid, req_op, op_a, op_b, op_c,
        input  res_valid, res
    );

    modport unit (
        input  req_valid, req_op, op_a, op_b, op_c,
        output res_valid, res
    );

endinterface

//--- rtl/sfm_fma_pipe.sv
`timescale 1ns/1ns
`include "sfm_params.svh"

module sfm_fma_pipe import sfm_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    sfm_fma_if.unit      fma
);

    localparam int unsigned STAGES = `SFM_FMA_STAGES;
    localparam int unsigned W      = `SFM_ACC_WIDTH;
    localparam int unsigned FRAC   = `SFM_FRAC_BITS;

    logic [2*W-1:0]    prod;
    acc_word_t         prod_trunc;
    acc_word_t         stage_res;

    logic [STAGES-1:0] valid_q;
    acc_word_t         data_q [STAGES];

    // first stage does all the arithmetic
    always_comb begin
        prod       = fma.op_a * fma.op_b;
        prod_trunc = prod[FRAC +: W];
        case (fma.req_op)
            OP_ADD:   stage_res = fma.op_a + fma.op_c;
            OP_MUL:   stage_res = prod_trunc;
            OP_NMADD: stage_res = fma.op_c - prod_trunc;
            default:  stage_res = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= fma.req_valid;
            for (int i = 1; i < STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // remaining stages only carry the value
    always_ff @(posedge clk_i) begin
        data_q[0] <= stage_res;
        for (int i = 1; i < STAGES; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign fma.res_valid = valid_q[STAGES-1];
    assign fma.res       = data_q[STAGES-1];

endmodule

//--- rtl/sfm_addend_fifo.sv
`timescale 1ns/1ns
`include "sfm_params.svh"

module sfm_addend_fifo import sfm_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      push_i,
    input  logic      pop_i,
    input  acc_word_t data_i,
    output acc_word_t data_o,
    output logic      full_o,
    output logic      empty_o
);

    localparam int unsigned DEPTH = `SFM_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    acc_word_t        mem_q [DEPTH];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    assign data_o  = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o);

endmodule

//--- rtl/sfm_den_inverter.sv
`timescale 1ns/1ns
`include "sfm_params.svh"

module sfm_den_inverter import sfm_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      clear_i,
    input  logic      start_i,
    input  acc_word_t den_i,
    output logic      done_o,
    output acc_word_t d_norm_o,
    output acc_word_t seed_o,
    output shift_t    shift_o
);

    localparam int unsigned W        = `SFM_ACC_WIDTH;
    localparam int unsigned FRAC     = `SFM_FRAC_BITS;
    localparam int          NORM_POS = `SFM_FRAC_BITS - 1;

    logic [$clog2(W)-1:0] lead_pos;
    acc_word_t            d_norm;
    shift_t               shift;
    logic [2*W-1:0]       seed_prod;

    logic      valid1_q;
    logic      valid2_q;
    acc_word_t d_norm1_q;
    acc_word_t d_norm2_q;
    shift_t    shift1_q;
    shift_t    shift2_q;
    acc_word_t seed_q;

    // highest set bit wins
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < W; i++) begin
            if (den_i[i]) begin
                lead_pos = i[$clog2(W)-1:0];
            end
        end
    end

    // move the leading one to bit 15, d_norm in [0.5, 1)
    always_comb begin
        shift = shift_t'(int'(lead_pos) - NORM_POS);
        if (int'(lead_pos) >= NORM_POS) begin
            d_norm = den_i >> (int'(lead_pos) - NORM_POS);
        end else begin
            d_norm = den_i << (NORM_POS - int'(lead_pos));
        end
    end

    assign seed_prod = `SFM_SEED_B * d_norm1_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid1_q <= 1'b0;
            valid2_q <= 1'b0;
        end else if (clear_i) begin
            valid1_q <= 1'b0;
            valid2_q <= 1'b0;
        end else begin
            valid1_q <= start_i;
            valid2_q <= valid1_q;
        end
    end

    always_ff @(posedge clk_i) begin
        d_norm1_q <= d_norm;
        shift1_q  <= shift;
        d_norm2_q <= d_norm1_q;
        shift2_q  <= shift1_q;
        seed_q    <= `SFM_SEED_A - seed_prod[FRAC +: W];
    end

    assign done_o   = valid2_q;
    assign d_norm_o = d_norm2_q;
    assign seed_o   = seed_q;
    assign shift_o  = shift2_q;

    // a zero sum has no leading one to normalize on
    a_den_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        start_i |-> den_i != '0);

endmodule

//--- rtl/sfm_acc_ctrl.sv
`timescale 1ns/1ns
`include "sfm_params.svh"

module sfm_acc_ctrl import sfm_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      clear_i,
    input  logic      add_valid_i,
    input  logic      finish_i,
    input  add_word_t add_i,
    input  acc_word_t fifo_head_i,
    input  logic      fifo_empty_i,
    input  logic      fifo_full_i,
    output logic      fifo_push_o,
    output logic      fifo_pop_o,
    output acc_word_t fifo_data_o,
    sfm_fma_if.ctrl   fma,
    output logic      inv_start_o,
    output acc_word_t inv_den_o,
    input  logic      inv_done_i,
    input  acc_word_t inv_d_norm_i,
    input  acc_word_t inv_seed_i,
    input  shift_t    inv_shift_i,
    output logic      ready_o,
    output logic      valid_o,
    output acc_word_t acc_o,
    output shift_t    shift_o
);

    localparam int unsigned STAGES  = `SFM_FMA_STAGES;
    localparam int unsigned ITERS   = `SFM_INV_ITERS;
    localparam int unsigned ITER_W  = $clog2(ITERS + 1);
    localparam acc_word_t   FMA_TWO = acc_word_t'(2 << `SFM_FRAC_BITS);

    acc_state_e  state_q, state_d;
    in_flight_t  in_flight_q;
    logic        red_toggle_q;
    logic [ITER_W-1:0] iter_q;
    acc_word_t   d_norm_q;
    acc_word_t   x_q;
    shift_t      shift_q;

    logic accept;
    logic busy;
    logic park;
    logic flight_inc, flight_dec;
    logic red_flip;
    logic iter_inc, iter_clr;
    logic load_seed, load_x;

    // no new addends while the sum is being reduced and inverted
    assign busy    = (state_q == REDUCTION) || (state_q == INVERSION) ||
                     (state_q == INV_FMA) || (state_q == INV_MUL);
    assign ready_o = !fifo_full_i && !busy;
    assign accept  = add_valid_i && ready_o;

    always_comb begin
        state_d       = state_q;
        fma.req_valid = 1'b0;
        fma.req_op    = OP_ADD;
        fma.op_a      = '0;
        fma.op_b      = '0;
        fma.op_c      = '0;
        fifo_pop_o    = 1'b0;
        park          = 1'b0;
        flight_inc    = 1'b0;
        flight_dec    = 1'b0;
        red_flip      = 1'b0;
        inv_start_o   = 1'b0;
        load_seed     = 1'b0;
        load_x        = 1'b0;
        iter_inc      = 1'b0;
        iter_clr      = 1'b0;

        unique case (state_q)
            IDLE, FINISHED: begin
                if (accept) begin
                    state_d = COMPUTING;
                end
            end
            COMPUTING, FINISHING: begin
                if (fma.res_valid) begin
                    // returning sum picks up the head, or zero to keep circulating
                    fma.req_valid = 1'b1;
                    fma.op_a      = fma.res;
                    if (!fifo_empty_i) begin
                        fma.op_c   = fifo_head_i;
                        fifo_pop_o = 1'b1;
                    end
                end else if (!fifo_empty_i && in_flight_q < STAGES) begin
                    fma.req_valid = 1'b1;
                    fma.op_c      = fifo_head_i;
                    fifo_pop_o    = 1'b1;
                    flight_inc    = 1'b1;
                end
                if (state_q == COMPUTING) begin
                    if (finish_i) begin
                        state_d = FINISHING;
                    end
                end else if (fifo_empty_i && !accept) begin
                    state_d = REDUCTION;
                end
            end
            REDUCTION: begin
                if (fma.res_valid) begin
                    if (in_flight_q == in_flight_t'(1)) begin
                        inv_start_o = 1'b1;
                        flight_dec  = 1'b1;
                        state_d     = INVERSION;
                    end else if (!red_toggle_q) begin
                        park     = 1'b1;
                        red_flip = 1'b1;
                    end else begin
                        fma.req_valid = 1'b1;
                        fma.op_a      = fma.res;
                        fma.op_c      = fifo_head_i;
                        fifo_pop_o    = 1'b1;
                        flight_dec    = 1'b1;
                        red_flip      = 1'b1;
                    end
                end
            end
            INVERSION: begin
                if (inv_done_i) begin
                    // e = 2 - d * x0
                    load_seed     = 1'b1;
                    fma.req_valid = 1'b1;
                    fma.req_op    = OP_NMADD;
                    fma.op_a      = inv_d_norm_i;
                    fma.op_b      = inv_seed_i;
                    fma.op_c      = FMA_TWO;
                    state_d       = INV_FMA;
                end
            end
            INV_FMA: begin
                if (fma.res_valid) begin
                    fma.req_valid = 1'b1;
                    fma.req_op    = OP_MUL;
                    fma.op_a      = x_q;
                    fma.op_b      = fma.res;
                    state_d       = INV_MUL;
                end
            end
            INV_MUL: begin
                if (fma.res_valid) begin
                    load_x = 1'b1;
                    if (iter_q == ITER_W'(ITERS - 1)) begin
                        iter_clr = 1'b1;
                        state_d  = FINISHED;
                    end else begin
                        iter_inc      = 1'b1;
                        fma.req_valid = 1'b1;
                        fma.req_op    = OP_NMADD;
                        fma.op_a      = d_norm_q;
                        fma.op_b      = fma.res;
                        fma.op_c      = FMA_TWO;
                        state_d       = INV_FMA;
                    end
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= IDLE;
            in_flight_q  <= '0;
            red_toggle_q <= 1'b0;
            iter_q       <= '0;
            x_q          <= '0;
            shift_q      <= '0;
        end else if (clear_i) begin
            state_q      <= IDLE;
            in_flight_q  <= '0;
            red_toggle_q <= 1'b0;
            iter_q       <= '0;
            x_q          <= '0;
            shift_q      <= '0;
        end else begin
            state_q <= state_d;
            if (flight_inc) begin
                in_flight_q <= in_flight_q + 1'b1;
            end else if (flight_dec) begin
                in_flight_q <= in_flight_q - 1'b1;
            end
            if (red_flip) begin
                red_toggle_q <= !red_toggle_q;
            end
            if (iter_clr) begin
                iter_q <= '0;
            end else if (iter_inc) begin
                iter_q <= iter_q + 1'b1;
            end
            if (load_seed) begin
                x_q     <= inv_seed_i;
                shift_q <= inv_shift_i;
            end else if (load_x) begin
                x_q <= fma.res;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_seed) begin
            d_norm_q <= inv_d_norm_i;
        end
    end

    assign fifo_push_o = accept || park;
    assign fifo_data_o = park ? fma.res : acc_word_t'(add_i);
    assign inv_den_o   = fma.res;
    assign valid_o     = (state_q == FINISHED);
    assign acc_o       = x_q;
    assign shift_o     = shift_q;

    // a full pipe hands back a sum every cycle
    a_flight_bound: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        (state_q inside {COMPUTING, FINISHING}) && in_flight_q == in_flight_t'(STAGES)
        |-> fma.res_valid);
    // seed must come back in time for the first NMADD
    a_inv_latency: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        inv_start_o |-> ##2 inv_done_i);

endmodule

//--- rtl/sfm_accumulator.sv
`timescale 1ns/1ns

module sfm_accumulator import sfm_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      clear_i,
    input  logic      add_valid_i,
    input  add_word_t add_i,
    input  logic      finish_i,
    output logic      ready_o,
    output logic      valid_o,
    output acc_word_t acc_o,
    output shift_t    shift_o
);

    logic      fifo_push;
    logic      fifo_pop;
    logic      fifo_full;
    logic      fifo_empty;
    acc_word_t fifo_wdata;
    acc_word_t fifo_head;

    logic      inv_start;
    logic      inv_done;
    acc_word_t inv_den;
    acc_word_t inv_d_norm;
    acc_word_t inv_seed;
    shift_t    inv_shift;

    sfm_fma_if fma_bus ();

    sfm_acc_ctrl i_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .clear_i      (clear_i),
        .add_valid_i  (add_valid_i),
        .finish_i     (finish_i),
        .add_i        (add_i),
        .fifo_head_i  (fifo_head),
        .fifo_empty_i (fifo_empty),
        .fifo_full_i  (fifo_full),
        .fifo_push_o  (fifo_push),
        .fifo_pop_o   (fifo_pop),
        .fifo_data_o  (fifo_wdata),
        .fma          (fma_bus),
        .inv_start_o  (inv_start),
        .inv_den_o    (inv_den),
        .inv_done_i   (inv_done),
        .inv_d_norm_i (inv_d_norm),
        .inv_seed_i   (inv_seed),
        .inv_shift_i  (inv_shift),
        .ready_o      (ready_o),
        .valid_o      (valid_o),
        .acc_o        (acc_o),
        .shift_o      (shift_o)
    );

    sfm_addend_fifo i_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (clear_i),
        .push_i  (fifo_push),
        .pop_i   (fifo_pop),
        .data_i  (fifo_wdata),
        .data_o  (fifo_head),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

    sfm_fma_pipe i_fma (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (clear_i),
        .fma     (fma_bus)
    );

    sfm_den_inverter i_inv (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .clear_i  (clear_i),
        .start_i  (inv_start),
        .den_i    (inv_den),
        .done_o   (inv_done),
        .d_norm_o (inv_d_norm),
        .seed_o   (inv_seed),
        .shift_o  (inv_shift)
    );

endmodule

//--- verification/tb_sfm_accumulator.sv
`timescale 1ns/1ns
`include "sfm_params.svh"

module tb_sfm_accumulator import sfm_pkg::*; ();

    localparam int          CLK_PERIOD      = 40;
    localparam int          RESET_CYCLES    = 8;
    localparam int          RESULT_TIMEOUT  = 100;
    localparam int          WATCHDOG_CYCLES = 20000;
    localparam acc_word_t   HALF_Q16        = 32'h0000_8000;
    localparam acc_word_t   ONE_Q16         = 32'h0001_0000;
    localparam logic [63:0] ONE_Q32         = 64'h0000_0001_0000_0000;
    localparam logic [63:0] TOL_Q32         = 64'h0000_0000_0010_0000;

    logic        clk_i;
    logic        rst_ni;
    logic        clear_i;
    logic        add_valid_i;
    add_word_t   add_i;
    logic        finish_i;
    logic        ready_o;
    logic        valid_o;
    acc_word_t   acc_o;
    shift_t      shift_o;

    int          errors;
    int          batches;
    int          seed;
    logic        idle_window;
    logic        track_ready;
    logic        ready_low_seen;
    acc_word_t   ref_sum;
    acc_word_t   exp_d_norm;
    acc_word_t   exp_recip;
    shift_t      exp_shift;
    logic [63:0] recip_prod;
    logic        recip_ok;

    sfm_accumulator i_dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .add_valid_i (add_valid_i),
        .add_i       (add_i),
        .finish_i    (finish_i),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .acc_o       (acc_o),
        .shift_o     (shift_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // product of reciprocal and d_norm should be close to 1.0 in Q32
    assign recip_prod = 64'(acc_o) * 64'(exp_d_norm);
    assign recip_ok   = (recip_prod > ONE_Q32 - TOL_Q32) && (recip_prod < ONE_Q32 + TOL_Q32);

    a_quiet_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        idle_window |-> !valid_o)
        else begin
            errors++;
            $display("Mismatch at %0t: valid_o = %b, expected 0", $time, $sampled(valid_o));
        end
    a_quiet_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        idle_window |-> ready_o)
        else begin
            errors++;
            $display("Mismatch at %0t: ready_o = %b, expected 1", $time, $sampled(ready_o));
        end
    a_shift: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(valid_o) |-> shift_o == exp_shift)
        else begin
            errors++;
            $display("Mismatch at %0t: shift_o = %0d, expected %0d",
                     $time, $sampled(shift_o), $sampled(exp_shift));
        end
    a_recip: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(valid_o) |-> recip_ok)
        else begin
            errors++;
            $display("Mismatch at %0t: acc_o = %h, expected about %h",
                     $time, $sampled(acc_o), $sampled(exp_recip));
        end
    a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !clear_i && !(add_valid_i && ready_o) |=> valid_o)
        else begin
            errors++;
            $display("Mismatch at %0t: valid_o = 0, expected 1", $time);
        end
    a_valid_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && add_valid_i && ready_o |=> !valid_o)
        else begin
            errors++;
            $display("Mismatch at %0t: valid_o = 1 after accepted addend, expected 0", $time);
        end
    a_clear_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        clear_i |=> !valid_o)
        else begin
            errors++;
            $display("Mismatch at %0t: valid_o = 1 after clear_i, expected 0", $time);
        end

    // note backpressure while the long batch runs
    always @(negedge clk_i) begin
        if (track_ready && !ready_o) begin
            ready_low_seen = 1'b1;
        end
    end

    task automatic idle_cycle();
        @(negedge clk_i);
        add_valid_i = 1'b0;
        finish_i    = 1'b0;
        clear_i     = 1'b0;
    endtask

    task automatic push_addend(add_word_t value);
        logic sent;
        sent = 1'b0;
        while (!sent) begin
            @(negedge clk_i);
            clear_i     = 1'b0;
            finish_i    = 1'b0;
            idle_window = 1'b0;
            add_valid_i = ready_o;
            if (ready_o) begin
                add_i   = value;
                ref_sum = ref_sum + acc_word_t'(value);
                sent    = 1'b1;
            end
        end
    endtask

    task automatic pulse_clear();
        @(negedge clk_i);
        add_valid_i = 1'b0;
        finish_i    = 1'b0;
        clear_i     = 1'b1;
        ref_sum     = '0;
        @(negedge clk_i);
        clear_i = 1'b0;
    endtask

    // scale the sum into [0.5, 1) and count the steps
    task automatic set_expected();
        acc_word_t norm;
        int        steps;
        norm  = ref_sum;
        steps = 0;
        while (norm >= ONE_Q16) begin
            norm = norm >> 1;
            steps++;
        end
        while (norm != '0 && norm < HALF_Q16) begin
            norm = norm << 1;
            steps--;
        end
        exp_d_norm = norm;
        exp_shift  = shift_t'(steps);
        exp_recip  = acc_word_t'(ONE_Q32 / 64'(norm));
    endtask

    task automatic finish_batch();
        int waited;
        @(negedge clk_i);
        add_valid_i = 1'b0;
        finish_i    = 1'b1;
        set_expected();
        @(negedge clk_i);
        finish_i = 1'b0;
        waited   = 0;
        while (!valid_o && waited < RESULT_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!valid_o) begin
            errors++;
            $display("no result within %0d cycles after finish_i at %0t", RESULT_TIMEOUT, $time);
        end
        batches++;
    endtask

    task automatic run_batch(int count, bit gaps);
        add_word_t   value;
        logic [31:0] gap;
        ref_sum = '0;
        for (int n = 0; n < count; n++) begin
            value = add_word_t'($random(seed));
            gap   = $random(seed);
            if (n == 0 && value == '0) begin
                value = 16'h0001;
            end
            if (gaps && gap[1:0] == 2'b00) begin
                idle_cycle();
            end
            push_addend(value);
        end
        finish_batch();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("%0d batches checked, %0d errors", batches, errors);
        $display("Something failed");
        $finish;
    end

    initial begin
        errors         = 0;
        batches        = 0;
        seed           = 32'he8ac_d880;
        rst_ni         = 1'b0;
        clear_i        = 1'b0;
        add_valid_i    = 1'b0;
        add_i          = '0;
        finish_i       = 1'b0;
        idle_window    = 1'b0;
        track_ready    = 1'b0;
        ready_low_seen = 1'b0;
        ref_sum        = '0;
        exp_d_norm     = HALF_Q16;
        exp_recip      = '0;
        exp_shift      = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni      = 1'b1;
        idle_window = 1'b1;
        repeat (4) idle_cycle();

        run_batch(5, 1'b1);
        // result held over a few quiet cycles, then the next batch takes over
        repeat (3) idle_cycle();
        run_batch(9, 1'b1);

        track_ready = 1'b1;
        run_batch(40, 1'b0);
        track_ready = 1'b0;
        a_ready_low: assert (ready_low_seen) else begin
            errors++;
            $display("ready_o never went low during the long batch");
        end

        // abandon a batch half way
        ref_sum = '0;
        for (int n = 0; n < 4; n++) begin
            push_addend(add_word_t'($random(seed)));
        end
        pulse_clear();
        run_batch(6, 1'b1);
        pulse_clear();
        repeat (3) idle_cycle();
        run_batch(1, 1'b0);
        repeat (2) idle_cycle();

        $display("%0d batches checked, %0d errors", batches, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
rtl/sfm_pkg.sv
rtl/sfm_fma_if.sv
rtl/sfm_fma_pipe.sv
rtl/sfm_addend_fifo.sv
rtl/sfm_den_inverter.sv
rtl/sfm_acc_ctrl.sv
rtl/sfm_accumulator.sv
verification/tb_sfm_accumulator.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_sfm_accumulator
FILELIST  := filelist.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Everything OK
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
